/* Makefile */
SIM        := verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
TOP        := tb_gpio_wb
RTL_TOP    := gpio_wb
FILELIST   := gpio_wb.f
OBJ_DIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* gpio_wb.f */
hw/gpio_pkg.sv
hw/gpio_wb_adapter.sv
hw/gpio_pad_sync.sv
hw/gpio_regs.sv
hw/gpio_wb.sv
tb/tb_gpio_checker.sv
tb/tb_gpio_wb.sv

/* hw/gpio_pad_sync.sv */
`timescale 1ns/1ns

module gpio_pad_sync (
    input  logic            clk,
    input  logic            resetn,
    input  gpio_pkg::pins_t pads_i,
    output gpio_pkg::pins_t pads_o
);

    import gpio_pkg::*;

    pins_t meta_q;                  // First stage, may go metastable
    pins_t sync_q;                  // Second stage, safe to use

    always_ff @(posedge clk) begin
        if (!resetn) begin
            meta_q <= '0;
            sync_q <= '0;
        end else begin
            meta_q <= pads_i;
            sync_q <= meta_q;
        end
    end

    assign pads_o = sync_q;

endmodule

/* hw/gpio_pkg.sv */
package gpio_pkg;

    // Bus address or data word
    typedef logic [31:0] word_t;

    // One strobe per byte lane
    typedef logic [3:0] strb_t;

    // One bit per GPIO pin
    typedef logic [15:0] pins_t;

    // Wishbone master to slave, 71 bits
    typedef struct packed {
        word_t adr;
        word_t dat;
        strb_t sel;
        logic  we;
        logic  cyc;
        logic  stb;
    } wb_req_t;

    // Wishbone slave to master, 33 bits
    typedef struct packed {
        word_t dat;
        logic  ack;
    } wb_rsp_t;

    // Simple memory request, 69 bits
    typedef struct packed {
        logic  valid;
        word_t addr;
        strb_t wstrb;      // Already masked by we
        word_t wdata;
    } mem_req_t;

    // Simple memory response, 33 bits
    typedef struct packed {
        word_t rdata;
        logic  ready;
    } mem_rsp_t;

    // Pad control outputs, 64 bits
    typedef struct packed {
        pins_t out;
        pins_t oeb;        // Active low output enable
        pins_t pu;
        pins_t pd;
    } pads_t;

endpackage

/* hw/gpio_regs.sv */
`timescale 1ns/1ns

module gpio_regs #(
    parameter gpio_pkg::word_t BASE_ADR = 32'h2100_0000,
    parameter logic [7:0]      DATA_OFS = 8'h00,
    parameter logic [7:0]      ENA_OFS  = 8'h04,
    parameter logic [7:0]      PU_OFS   = 8'h08,
    parameter logic [7:0]      PD_OFS   = 8'h0c
) (
    input  logic               clk,
    input  logic               resetn,
    input  gpio_pkg::mem_req_t mem_req_i,
    output gpio_pkg::mem_rsp_t mem_rsp_o,
    input  gpio_pkg::pins_t    pins_i,
    output gpio_pkg::pads_t    pads_o
);

    import gpio_pkg::*;

    typedef enum logic {
        IDLE,
        ACK
    } state_e;

    state_e state_q;
    state_e state_d;

    pads_t pads_q;
    word_t rdata_q;
    word_t rd_word;

    logic in_page;
    logic req_hit;
    logic accept;
    logic sel_data;
    logic sel_oeb;
    logic sel_pu;
    logic sel_pd;

    // Lanes 0 and 1 only, upper lanes have no storage
    function automatic pins_t lane_merge(input pins_t cur, input word_t wdata,
                                         input strb_t wstrb);
        pins_t res;
        res = cur;
        if (wstrb[0]) begin
            res[7:0] = wdata[7:0];
        end
        if (wstrb[1]) begin
            res[15:8] = wdata[15:8];
        end
        return res;
    endfunction

    assign in_page  = (mem_req_i.addr[31:8] == BASE_ADR[31:8]);
    assign sel_data = (mem_req_i.addr[7:0] == DATA_OFS);
    assign sel_oeb  = (mem_req_i.addr[7:0] == ENA_OFS);
    assign sel_pu   = (mem_req_i.addr[7:0] == PU_OFS);
    assign sel_pd   = (mem_req_i.addr[7:0] == PD_OFS);

    assign req_hit = mem_req_i.valid && in_page;
    assign accept  = req_hit && (state_q == IDLE);  // Ignored while ready is high

    // One-cycle ready pulse
    always_comb begin
        state_d = IDLE;
        case (state_q)
            IDLE: begin
                if (req_hit) begin
                    state_d = ACK;
                end
            end
            ACK: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Read-back word, unmapped offsets read zero
    always_comb begin
        rd_word = '0;
        if (sel_data) begin
            rd_word = {pads_q.out, pins_i};
        end else if (sel_oeb) begin
            rd_word = {16'h0000, pads_q.oeb};
        end else if (sel_pu) begin
            rd_word = {16'h0000, pads_q.pu};
        end else if (sel_pd) begin
            rd_word = {16'h0000, pads_q.pd};
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pads_q.out <= '0;
            pads_q.oeb <= '1;               // All pins start as inputs
            pads_q.pu  <= '0;
            pads_q.pd  <= '0;
        end else if (accept) begin
            if (sel_data) begin
                pads_q.out <= lane_merge(pads_q.out, mem_req_i.wdata, mem_req_i.wstrb);
            end else if (sel_oeb) begin
                pads_q.oeb <= lane_merge(pads_q.oeb, mem_req_i.wdata, mem_req_i.wstrb);
            end else if (sel_pu) begin
                pads_q.pu <= lane_merge(pads_q.pu, mem_req_i.wdata, mem_req_i.wstrb);
            end else if (sel_pd) begin
                pads_q.pd <= lane_merge(pads_q.pd, mem_req_i.wdata, mem_req_i.wstrb);
            end
        end
    end

    // Captured at the accepting edge, valid with ready
    always_ff @(posedge clk) begin
        if (accept) begin
            rdata_q <= rd_word;
        end
    end

    assign mem_rsp_o.rdata = rdata_q;
    assign mem_rsp_o.ready = (state_q == ACK);
    assign pads_o          = pads_q;

    ready_single_cycle: assert property (
        @(posedge clk) disable iff (!resetn)
        mem_rsp_o.ready |=> !mem_rsp_o.ready
    ) else $error("ready high for two cycles");

    ready_after_request: assert property (
        @(posedge clk) disable iff (!resetn)
        mem_rsp_o.ready |-> $past(mem_req_i.valid && in_page)
    ) else $error("ready without a prior in-page request");

    pulls_reset: assert property (
        @(posedge clk)
        !resetn |=> (pads_o.pu == '0) && (pads_o.pd == '0)
    ) else $error("pull enables not cleared by reset");

endmodule

/* hw/gpio_wb.sv */
`timescale 1ns/1ns

module gpio_wb #(
    parameter gpio_pkg::word_t BASE_ADR = 32'h2100_0000,
    parameter logic [7:0]      DATA_OFS = 8'h00,
    parameter logic [7:0]      ENA_OFS  = 8'h04,
    parameter logic [7:0]      PU_OFS   = 8'h08,
    parameter logic [7:0]      PD_OFS   = 8'h0c
) (
    input  logic              clk,
    input  logic              resetn,
    input  gpio_pkg::wb_req_t wb_req_i,
    output gpio_pkg::wb_rsp_t wb_rsp_o,
    input  gpio_pkg::pins_t   pads_in_i,
    output gpio_pkg::pads_t   pads_o
);

    import gpio_pkg::*;

    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    pins_t    pins_sync;            // Pad inputs in the clk domain

    // Bus protocol boundary
    gpio_wb_adapter u_adapter (
        .wb_req_i  (wb_req_i),
        .wb_rsp_o  (wb_rsp_o),
        .mem_req_o (mem_req),
        .mem_rsp_i (mem_rsp)
    );

    gpio_pad_sync u_pad_sync (
        .clk    (clk),
        .resetn (resetn),
        .pads_i (pads_in_i),
        .pads_o (pins_sync)
    );

    gpio_regs #(
        .BASE_ADR (BASE_ADR),
        .DATA_OFS (DATA_OFS),
        .ENA_OFS  (ENA_OFS),
        .PU_OFS   (PU_OFS),
        .PD_OFS   (PD_OFS)
    ) u_regs (
        .clk       (clk),
        .resetn    (resetn),
        .mem_req_i (mem_req),
        .mem_rsp_o (mem_rsp),
        .pins_i    (pins_sync),
        .pads_o    (pads_o)
    );

endmodule

/* hw/gpio_wb_adapter.sv */
`timescale 1ns/1ns

module gpio_wb_adapter (
    input  gpio_pkg::wb_req_t  wb_req_i,
    output gpio_pkg::wb_rsp_t  wb_rsp_o,
    output gpio_pkg::mem_req_t mem_req_o,
    input  gpio_pkg::mem_rsp_t mem_rsp_i
);

    import gpio_pkg::*;

    strb_t wr_lanes;
    logic  bus_valid;

    // Strobe and cycle together open a request
    assign bus_valid = wb_req_i.cyc && wb_req_i.stb;

    // Reads carry no byte enables
    assign wr_lanes = wb_req_i.we ? wb_req_i.sel : '0;

    assign mem_req_o.valid = bus_valid;
    assign mem_req_o.addr  = wb_req_i.adr;
    assign mem_req_o.wstrb = wr_lanes;
    assign mem_req_o.wdata = wb_req_i.dat;

    // Response goes straight back to the bus
    assign wb_rsp_o.dat = mem_rsp_i.rdata;
    assign wb_rsp_o.ack = mem_rsp_i.ready;

    // A master holds cyc until it has seen ack, so ack without cyc means
    // the slave answered a cycle that was never opened or was abandoned
    always_comb begin
        ack_within_cycle: assert final (!(mem_rsp_i.ready && !wb_req_i.cyc))
            else $error("ack while cyc is low");
    end

endmodule

/* tb/tb_gpio_checker.sv */
`timescale 1ns/1ns

module tb_gpio_checker #(
    parameter gpio_pkg::word_t BASE_ADR = 32'h2100_0000
) (
    input  logic              clk,
    input  logic              resetn,
    input  gpio_pkg::wb_req_t wb_req_i,
    input  gpio_pkg::wb_rsp_t wb_rsp_i,
    input  gpio_pkg::pads_t   pads_i,
    input  gpio_pkg::pads_t   exp_pads_i,
    input  gpio_pkg::word_t   exp_rdata_i,
    output int                err_cnt_o,
    output int                chk_cnt_o
);

    import gpio_pkg::*;

    int   err_cnt = 0;
    int   chk_cnt = 0;
    logic prev_req = 1'b0;          // In-page request seen at the last edge
    logic prev_ack = 1'b0;          // Expected ack at the last edge
    logic exp_ack;

    task automatic report_fail(input string msg);
        err_cnt++;
        $display("[FAIL] t=%0t ns %s", $time, msg);
    endtask

    // Sampled at the rising edge before the DUT updates
    always @(posedge clk) begin
        if (!resetn) begin
            prev_req = 1'b0;
            prev_ack = 1'b0;
        end else begin
            // One cycle after a request but never right after an ack
            exp_ack = prev_req && !prev_ack;
            chk_cnt++;
            if (wb_rsp_i.ack !== exp_ack) begin
                report_fail($sformatf("ack=%b expected %b adr=%h", wb_rsp_i.ack, exp_ack,
                                      wb_req_i.adr));
            end
            if (wb_rsp_i.ack && !wb_req_i.we) begin
                chk_cnt++;
                if (wb_rsp_i.dat !== exp_rdata_i) begin
                    report_fail($sformatf("read %h from %h expected %h", wb_rsp_i.dat,
                                          wb_req_i.adr, exp_rdata_i));
                end
            end
            chk_cnt++;
            if (pads_i !== exp_pads_i) begin
                report_fail($sformatf("pads out=%h oeb=%h pu=%h pd=%h expected %h %h %h %h",
                                      pads_i.out, pads_i.oeb, pads_i.pu, pads_i.pd,
                                      exp_pads_i.out, exp_pads_i.oeb, exp_pads_i.pu,
                                      exp_pads_i.pd));
            end
            prev_req = wb_req_i.cyc && wb_req_i.stb
                       && (wb_req_i.adr[31:8] == BASE_ADR[31:8]);
            prev_ack = exp_ack;
        end
    end

    assign err_cnt_o = err_cnt;
    assign chk_cnt_o = chk_cnt;

endmodule

/* tb/tb_gpio_wb.sv */
`timescale 1ns/1ns

module tb_gpio_wb;

    import gpio_pkg::*;

    localparam word_t      BASE_ADR   = 32'h2100_0000;
    localparam logic [7:0] DATA_OFS   = 8'h00;
    localparam logic [7:0] ENA_OFS    = 8'h04;
    localparam logic [7:0] PU_OFS     = 8'h08;
    localparam logic [7:0] PD_OFS     = 8'h0c;
    localparam int         CLK_PERIOD = 8;
    localparam int         N_RAND     = 150;
    localparam int         N_STRAY    = 12;
    localparam int         N_HELD     = 10;
    localparam int         N_TXN      = N_RAND + N_STRAY + N_HELD + 4 + 2;
    localparam int         WATCHDOG   = N_TXN * 10 * CLK_PERIOD;
    localparam int         ACK_LIMIT  = 8;

    logic    clk;
    logic    resetn;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    pins_t   pads_in;
    pads_t   pads;
    pads_t   model_pads;            // Register model
    word_t   exp_rdata;
    word_t   rng_state;
    int      bus_errs;
    int      chk_errs;
    int      chk_cnt;

    gpio_wb #(
        .BASE_ADR (BASE_ADR),
        .DATA_OFS (DATA_OFS),
        .ENA_OFS  (ENA_OFS),
        .PU_OFS   (PU_OFS),
        .PD_OFS   (PD_OFS)
    ) u_dut (
        .clk       (clk),
        .resetn    (resetn),
        .wb_req_i  (wb_req),
        .wb_rsp_o  (wb_rsp),
        .pads_in_i (pads_in),
        .pads_o    (pads)
    );

    tb_gpio_checker #(
        .BASE_ADR (BASE_ADR)
    ) u_checker (
        .clk         (clk),
        .resetn      (resetn),
        .wb_req_i    (wb_req),
        .wb_rsp_i    (wb_rsp),
        .pads_i      (pads),
        .exp_pads_i  (model_pads),
        .exp_rdata_i (exp_rdata),
        .err_cnt_o   (chk_errs),
        .chk_cnt_o   (chk_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic word_t next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state ^ (rng_state >> 16);
    endfunction

    // Mostly mapped offsets with about a quarter unmapped
    function automatic logic [7:0] pick_offset(input word_t r);
        logic [7:0] off;
        if (r[2:0] < 3'd6) begin
            off = {4'h0, r[4:3], 2'b00};
        end else begin
            off = r[15:8];
            if (off == DATA_OFS || off == ENA_OFS || off == PU_OFS || off == PD_OFS) begin
                off = off ^ 8'h40;
            end
        end
        return off;
    endfunction

    function automatic word_t expected_read(input logic [7:0] off);
        word_t res;
        res = '0;
        case (off)
            DATA_OFS: res = {model_pads.out, pads_in};
            ENA_OFS:  res = {16'h0000, model_pads.oeb};
            PU_OFS:   res = {16'h0000, model_pads.pu};
            PD_OFS:   res = {16'h0000, model_pads.pd};
            default:  res = '0;
        endcase
        return res;
    endfunction

    // Lanes 2 and 3 have no effect
    task automatic apply_write(input logic [7:0] off, input word_t dat, input strb_t sel);
        pins_t mask;
        mask = {{8{sel[1]}}, {8{sel[0]}}};
        case (off)
            DATA_OFS: model_pads.out = (model_pads.out & ~mask) | (dat[15:0] & mask);
            ENA_OFS:  model_pads.oeb = (model_pads.oeb & ~mask) | (dat[15:0] & mask);
            PU_OFS:   model_pads.pu  = (model_pads.pu & ~mask) | (dat[15:0] & mask);
            PD_OFS:   model_pads.pd  = (model_pads.pd & ~mask) | (dat[15:0] & mask);
            default:  ;
        endcase
    endtask

    task automatic hold_pads();
        @(posedge clk);
        pads_in <= 16'(next_rand() >> 8);
        repeat (3) @(posedge clk);      // Past the synchronizer
    endtask

    task automatic drive_req(input word_t adr, input word_t dat, input strb_t sel,
                             input logic we);
        wb_req.adr <= adr;
        wb_req.dat <= dat;
        wb_req.sel <= sel;
        wb_req.we  <= we;
        wb_req.cyc <= 1'b1;
        wb_req.stb <= 1'b1;
    endtask

    task automatic drop_req();
        @(posedge clk);
        wb_req.cyc <= 1'b0;
        wb_req.stb <= 1'b0;
        wb_req.we  <= 1'b0;
    endtask

    // Strobe stays up until n_acks acks were seen
    task automatic bus_access(input logic [7:0] off, input word_t dat, input strb_t sel,
                              input logic we, input int n_acks);
        int seen;
        int waited;
        seen = 0;
        waited = 0;
        @(posedge clk);
        exp_rdata <= we ? '0 : expected_read(off);
        drive_req(BASE_ADR | {24'h0, off}, dat, sel, we);
        while (seen < n_acks && waited < ACK_LIMIT * n_acks) begin
            @(negedge clk);
            waited++;
            if (wb_rsp.ack) begin
                seen++;
                if (we) begin
                    apply_write(off, dat, sel);
                end
            end
        end
        if (seen < n_acks) begin
            bus_errs++;
            $display("ERROR: access to offset %h got %0d of %0d acks", off, seen, n_acks);
        end
        drop_req();
    endtask

    task automatic stray_access(input word_t adr, input word_t dat, input strb_t sel,
                                input logic we);
        @(posedge clk);
        drive_req(adr, dat, sel, we);
        repeat (4) @(negedge clk);      // Checker flags any ack here
        drop_req();
    endtask

    initial begin
        word_t      r;
        word_t      adr;
        logic [7:0] off;
        rng_state = 32'd41;
        bus_errs = 0;
        model_pads.out = '0;
        model_pads.oeb = '1;
        model_pads.pu = '0;
        model_pads.pd = '0;
        resetn <= 1'b0;
        wb_req <= '0;
        pads_in <= '0;
        exp_rdata <= '0;
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        repeat (3) @(posedge clk);      // Reset state checked before any access

        for (int i = 0; i < N_RAND; i++) begin
            r = next_rand();
            off = pick_offset(r);
            if (!r[5]) begin
                hold_pads();
            end
            bus_access(off, next_rand(), 4'(next_rand() >> 28), r[5], 1);
        end

        // Register offsets inside a foreign page
        for (int i = 0; i < N_STRAY; i++) begin
            r = next_rand();
            adr = next_rand();
            if (adr[31:8] == BASE_ADR[31:8]) begin
                adr[31] = ~adr[31];
            end
            adr[7:0] = pick_offset(r);
            stray_access(adr, next_rand(), 4'hf, r[5]);
        end
        for (int i = 0; i < 4; i++) begin
            hold_pads();
            bus_access(8'(i * 4), '0, 4'h0, 1'b0, 1);
        end

        for (int i = 0; i < N_HELD; i++) begin
            r = next_rand();
            hold_pads();
            bus_access({4'h0, r[4:3], 2'b00}, next_rand(), r[11:8], r[5], 3);
        end

        repeat (4) @(posedge clk);
        $display("checks=%0d checker_errors=%0d bus_errors=%0d", chk_cnt, chk_errs, bus_errs);
        if (chk_errs == 0 && bus_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG);
        $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG);
        $display("TEST FAILED");
        $finish;
    end

endmodule
